// File: src.f
design/ddr_geom_pkg.sv
design/ddr_cmd_pkg.sv
design/xfer_req_if.sv
design/cmd_encod_linear.sv
design/cmd_encod_linear_rw.sv
design/cmd_seq_buf.sv
design/cmd_linear_top.sv
testbench/tb_cmd_linear.sv

// File: run.sh
#!/bin/sh
# compile and run with Verilator; pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cmd_linear -f src.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: testbench/tb_cmd_linear.sv
// one sequence per start, each after the previous seq_done; request fields from $random, fixed seed
`timescale 1ns/1ps
module tb_cmd_linear;
    import ddr_geom_pkg::*;
    import ddr_cmd_pkg::*;

    localparam int CLK_HALF     = 5;    // 10 ns period
    localparam int RST_CYCLES   = 8;
    localparam int DONE_TIMEOUT = 200;  // 66 words plus pipeline fits easily
    localparam int NUM_RANDOM   = 10;

    logic                     clk;
    logic                     rst;
    bank_t                    bank_in;
    row_t                     row_in;
    col8_t                    start_col;
    xfer_num_t                num128_in;
    logic                     skip_next_page_in;
    logic                     start_rd;
    logic                     start_wr;
    logic [BUF_ADDR_BITS-1:0] rd_addr;
    logic                     start;
    logic                     busy;
    logic                     seq_done;
    logic [7:0]               cmd_count;
    enc_cmd_t                 rd_data;
    integer                   seed;  // $random state

    cmd_linear_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .bank_in           (bank_in),
        .row_in            (row_in),
        .start_col         (start_col),
        .num128_in         (num128_in),
        .skip_next_page_in (skip_next_page_in),
        .start_rd          (start_rd),
        .start_wr          (start_wr),
        .rd_addr           (rd_addr),
        .start             (start),
        .busy              (busy),
        .seq_done          (seq_done),
        .cmd_count         (cmd_count),
        .rd_data           (rd_data)
    );

    always #CLK_HALF clk = ~clk;

    // word idx of one sequence: ACTIVATE, n column words, PRECHARGE
    function automatic enc_cmd_t expected_word(input xfer_dir_e dir, input bank_t bank,
                                               input row_t row, input col8_t col,
                                               input xfer_num_t num, input logic skip,
                                               input int idx);
        enc_cmd_t w;
        int       n;
        int       k;
        n          = (num == '0) ? 64 : int'(num);  // 0 means 64 bursts
        k          = idx - 1;                       // column index
        w          = '0;
        w.bank     = bank;
        w.late_sel = (dir == DIR_RD);               // reads in late slot
        if (idx == 0) begin
            w.op    = ACTIVATE;
            w.addr  = row;
            w.pause = 6'd4;                         // tRCD
        end else if (idx <= n) begin
            w.op      = (dir == DIR_WR) ? WRITE : READ;
            w.addr    = row_t'(((int'(col) + k) % 128) * 8);  // wraps, low 3 bits zero
            w.buf_inc = 1'b1;
            w.buf_rst = (k == 0) && !skip;
            w.dq_en   = (dir == DIR_WR);
            if (k == n - 1) begin
                w.pause = (dir == DIR_WR) ? 6'd6 : 6'd2;    // write recovery vs burst
            end
        end else begin
            w.op   = PRECHARGE;
            w.done = 1'b1;
        end
        return w;
    endfunction

    task automatic fail_stop();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_cmd(input string name, input enc_cmd_t got, input enc_cmd_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic wait_seq_done();
        int cycles;
        cycles = 0;
        while (seq_done !== 1'b1) begin
            if (cycles >= DONE_TIMEOUT) begin
                $display("timeout: seq_done did not rise within %0d cycles", DONE_TIMEOUT);
                fail_stop();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic draw_fields(output bank_t bank, output row_t row, output col8_t col,
                               output xfer_num_t num);
        bank = bank_t'($random(seed));
        row  = row_t'($random(seed));
        col  = col8_t'($random(seed));
        num  = xfer_num_t'($random(seed));
    endtask

    // strobe, check start and busy, wait for done, then read back every word
    task automatic run_sequence(input xfer_dir_e dir, input bank_t bank, input row_t row,
                                input col8_t col, input xfer_num_t num, input logic skip);
        int n;
        n = (num == '0) ? 64 : int'(num);
        @(posedge clk);
        bank_in           <= bank;
        row_in            <= row;
        start_col         <= col;
        num128_in         <= num;
        skip_next_page_in <= skip;
        start_rd          <= (dir == DIR_RD);
        start_wr          <= (dir == DIR_WR);
        @(negedge clk);
        check_bit("start", start, 1'b0);  // strobe cycle
        @(posedge clk);
        start_rd <= 1'b0;
        start_wr <= 1'b0;
        @(negedge clk);
        check_bit("start", start, 1'b1);  // one cycle after strobe
        check_bit("busy", busy, 1'b1);
        @(negedge clk);
        check_bit("start", start, 1'b0);
        wait_seq_done();
        check_count("cmd_count", cmd_count, 8'(n + 2));
        check_bit("busy", busy, 1'b0);    // encoder idle before buffered done
        for (int i = 0; i <= n + 2; i++) begin
            @(posedge clk);
            if (i < n + 2) begin
                rd_addr <= 7'(i);
            end
            @(negedge clk);
            if (i > 0) begin              // data lags address by one cycle
                check_cmd($sformatf("rd_data[%0d]", i - 1), rd_data,
                          expected_word(dir, bank, row, col, num, skip, i - 1));
            end
        end
    endtask

    initial begin
        bank_t     bank;
        row_t      row;
        col8_t     col;
        xfer_num_t num;
        logic      skip;
        xfer_dir_e dir;
        seed              = 32'h3fd0_8e42;
        clk               = 1'b0;
        rst               = 1'b1;
        bank_in           = '0;
        row_in            = '0;
        start_col         = '0;
        num128_in         = '0;
        skip_next_page_in = 1'b0;
        start_rd          = 1'b0;
        start_wr          = 1'b0;
        rd_addr           = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("start", start, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("seq_done", seq_done, 1'b0);
        check_count("cmd_count", cmd_count, 8'd0);
        // read then write with nonzero burst count
        draw_fields(bank, row, col, num);
        run_sequence(DIR_RD, bank, row, col, (num == '0) ? 6'd1 : num, 1'b0);
        draw_fields(bank, row, col, num);
        run_sequence(DIR_WR, bank, row, col, (num == '0) ? 6'd1 : num, 1'b0);
        // 64 bursts across the column wrap, short write at the last column
        draw_fields(bank, row, col, num);
        run_sequence(DIR_RD, bank, row, 7'd125, 6'd0, 1'b0);
        run_sequence(DIR_WR, bank, row, 7'd127, 6'd3, 1'b0);
        // continuing page, no buffer restart
        draw_fields(bank, row, col, num);
        run_sequence(DIR_WR, bank, row, col, num, 1'b1);
        draw_fields(bank, row, col, num);
        run_sequence(DIR_RD, bank, row, col, num, 1'b1);
        for (int t = 0; t < NUM_RANDOM; t++) begin
            draw_fields(bank, row, col, num);
            dir  = (($random(seed) & 32'd1) != 0) ? DIR_WR : DIR_RD;
            skip = (($random(seed) & 32'd1) != 0);
            run_sequence(dir, bank, row, col, num, skip);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: design/cmd_linear_top.sv
`timescale 1ns/1ps
// linear command encoder with readback buffer; client issues one start per sequence, after seq_done
module cmd_linear_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  ddr_geom_pkg::bank_t                     bank_in,
    input  ddr_geom_pkg::row_t                      row_in,
    input  ddr_geom_pkg::col8_t                     start_col,
    input  ddr_geom_pkg::xfer_num_t                 num128_in,
    input  logic                                    skip_next_page_in,
    input  logic                                    start_rd,
    input  logic                                    start_wr,
    input  logic [ddr_geom_pkg::BUF_ADDR_BITS-1:0]  rd_addr,
    output logic                                    start,
    output logic                                    busy,
    output logic                                    seq_done,
    output logic [7:0]                              cmd_count,
    output ddr_cmd_pkg::enc_cmd_t                   rd_data
);
    import ddr_cmd_pkg::*;

    xfer_req_if u_req ();

    enc_cmd_t enc_cmd;   // registered combiner output
    logic     enc_wr;
    logic     enc_done;

    // source side of the request
    assign u_req.bank           = bank_in;
    assign u_req.row            = row_in;
    assign u_req.start_col      = start_col;
    assign u_req.num128         = num128_in;
    assign u_req.skip_next_page = skip_next_page_in;

    cmd_encod_linear_rw u_enc (
        .clk      (clk),
        .rst      (rst),
        .req      (u_req.sink),
        .start_rd (start_rd),
        .start_wr (start_wr),
        .start    (start),
        .enc_cmd  (enc_cmd),
        .enc_wr   (enc_wr),
        .enc_done (enc_done),
        .busy     (busy)
    );

    cmd_seq_buf u_buf (
        .clk       (clk),
        .rst       (rst),
        .start     (start),     // arrives one cycle before word 0
        .enc_cmd   (enc_cmd),
        .enc_wr    (enc_wr),
        .enc_done  (enc_done),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .cmd_count (cmd_count),
        .seq_done  (seq_done)
    );

endmodule

// File: design/cmd_seq_buf.sv
`timescale 1ns/1ps
// holds one sequence of at most 128 words; a new start overwrites from address 0, no overflow wrap
module cmd_seq_buf (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,      // clears write pointer
    input  ddr_cmd_pkg::enc_cmd_t                   enc_cmd,
    input  logic                                    enc_wr,
    input  logic                                    enc_done,
    input  logic [ddr_geom_pkg::BUF_ADDR_BITS-1:0]  rd_addr,
    output ddr_cmd_pkg::enc_cmd_t                   rd_data,    // one cycle after rd_addr
    output logic [7:0]                              cmd_count,  // words in last sequence
    output logic                                    seq_done
);
    import ddr_geom_pkg::*;
    import ddr_cmd_pkg::*;

    enc_cmd_t               mem [BUF_DEPTH];
    logic [BUF_ADDR_BITS:0] wr_ptr;  // extra bit marks full

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            cmd_count <= '0;
            seq_done  <= 1'b0;
        end else begin
            seq_done <= enc_done;
            if (start) begin
                wr_ptr    <= '0;
                cmd_count <= '0;
            end else begin
                if (enc_wr) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (enc_done) begin
                    cmd_count <= wr_ptr;  // last word already counted
                end
            end
        end
    end

    // word storage and read port
    always_ff @(posedge clk) begin
        if (enc_wr) begin
            mem[wr_ptr[BUF_ADDR_BITS-1:0]] <= enc_cmd;
        end
        rd_data <= mem[rd_addr];
    end

    // sequence longer than the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        enc_wr |-> !wr_ptr[BUF_ADDR_BITS]);

endmodule

// File: design/cmd_encod_linear_rw.sv
`timescale 1ns/1ps
// read and write encoders share one request; only one of them may run, output lags by one cycle
module cmd_encod_linear_rw (
    input  logic                  clk,
    input  logic                  rst,
    xfer_req_if.sink              req,
    input  logic                  start_rd,  // read strobe
    input  logic                  start_wr,  // write strobe
    output logic                  start,     // one cycle after either strobe
    output ddr_cmd_pkg::enc_cmd_t enc_cmd,
    output logic                  enc_wr,
    output logic                  enc_done,
    output logic                  busy
);
    import ddr_cmd_pkg::*;

    enc_cmd_t cmd_rd;
    enc_cmd_t cmd_wr;
    logic     wr_rd;
    logic     wr_wr;
    logic     done_rd;
    logic     done_wr;
    logic     busy_rd;
    logic     busy_wr;
    logic     select_wr;  // 0 after reset, read

    cmd_encod_linear #(
        .DIR      (DIR_RD),
        .LATE_SEL (1'b1)    // reads in late slot
    ) u_enc_rd (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .start    (start_rd),
        .enc_cmd  (cmd_rd),
        .enc_wr   (wr_rd),
        .enc_done (done_rd),
        .busy     (busy_rd)
    );

    cmd_encod_linear #(
        .DIR      (DIR_WR),
        .LATE_SEL (1'b0)    // writes in early slot
    ) u_enc_wr (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .start    (start_wr),
        .enc_cmd  (cmd_wr),
        .enc_wr   (wr_wr),
        .enc_done (done_wr),
        .busy     (busy_wr)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start     <= 1'b0;
            select_wr <= 1'b0;
            enc_wr    <= 1'b0;
            enc_done  <= 1'b0;
        end else begin
            start <= start_rd || start_wr;
            if (start_rd) begin
                select_wr <= 1'b0;
            end else if (start_wr) begin
                select_wr <= 1'b1;
            end
            enc_wr   <= select_wr ? wr_wr : wr_rd;     // select already valid on word 0
            enc_done <= select_wr ? done_wr : done_rd;
        end
    end

    always_ff @(posedge clk) begin
        enc_cmd <= select_wr ? cmd_wr : cmd_rd;
    end

    assign busy = busy_rd || busy_wr;

    // one direction per strobe
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(start_rd && start_wr));

endmodule

// File: design/cmd_encod_linear.sv
`timescale 1ns/1ps
// one sequence at a time, no back-pressure; a start while busy is a client error, column wraps at 128
module cmd_encod_linear #(
    parameter ddr_cmd_pkg::xfer_dir_e DIR      = ddr_cmd_pkg::DIR_RD,  // column opcode, last pause
    parameter logic                   LATE_SEL = 1'b0                  // late/early command slot
) (
    input  logic                  clk,
    input  logic                  rst,
    xfer_req_if.sink              req,
    input  logic                  start,     // single-cycle strobe
    output ddr_cmd_pkg::enc_cmd_t enc_cmd,   // current word
    output logic                  enc_wr,    // word valid
    output logic                  enc_done,  // pulse after last word
    output logic                  busy
);
    import ddr_geom_pkg::*;
    import ddr_cmd_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ACT,
        COL,
        PRE,
        DONE
    } state_e;

    state_e                    state;
    bank_t                     bank_r;    // latched request
    row_t                      row_r;
    col8_t                     col_r;     // wrapping column pointer
    logic                      skip_r;
    xfer_num_t                 left_r;    // column words left minus one
    logic                      first_r;   // first column word pending
    logic                      last_col;
    logic                      take_req;
    logic [COLADDR_NUMBER-1:0] col_addr;  // column in bursts of 8

    assign take_req = (state == IDLE) && start;
    assign last_col = (left_r == '0);
    assign col_addr = {col_r, 3'b000};  // 8-burst aligned

    // sequence control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            left_r  <= '0;
            first_r <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= ACT;
                        left_r  <= req.num128 - xfer_num_t'(1);  // 0 wraps to 63, i.e. 64 bursts
                        first_r <= 1'b1;
                    end
                end
                ACT: begin
                    state <= COL;
                end
                COL: begin
                    first_r <= 1'b0;
                    if (last_col) begin
                        state <= PRE;
                    end else begin
                        left_r <= left_r - xfer_num_t'(1);
                    end
                end
                PRE: begin
                    state <= DONE;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request fields and column pointer
    always_ff @(posedge clk) begin
        if (take_req) begin
            bank_r <= req.bank;
            row_r  <= req.row;
            col_r  <= req.start_col;
            skip_r <= req.skip_next_page;
        end else if (state == COL) begin
            col_r <= col_r + col8_t'(1);  // wraps modulo 128
        end
    end

    // word builder
    always_comb begin
        enc_cmd          = '0;
        enc_cmd.op       = NOP;
        enc_cmd.bank     = bank_r;
        enc_cmd.late_sel = LATE_SEL;
        case (state)
            ACT: begin
                enc_cmd.op    = ACTIVATE;
                enc_cmd.addr  = row_r;
                enc_cmd.pause = T_RCD_PAUSE;
            end
            COL: begin
                if (DIR == DIR_WR) begin
                    enc_cmd.op = WRITE;
                end else begin
                    enc_cmd.op = READ;
                end
                enc_cmd.addr    = row_t'(col_addr);          // zero fill above column
                enc_cmd.buf_inc = 1'b1;
                enc_cmd.buf_rst = first_r && !skip_r;        // new page unless continuing
                enc_cmd.dq_en   = (DIR == DIR_WR);
                enc_cmd.pause   = last_col ? T_WR_PAUSE[DIR] : '0;
            end
            PRE: begin
                enc_cmd.op   = PRECHARGE;
                enc_cmd.done = 1'b1;
            end
            default: begin
                enc_cmd.op = NOP;
            end
        endcase
    end

    assign enc_wr   = (state == ACT) || (state == COL) || (state == PRE);
    assign enc_done = (state == DONE);
    assign busy     = (state != IDLE);

    // client waits for done before the next strobe
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

    // done closes a sequence ended by the precharge word, never with a word
    a_done_after_pre: assert property (@(posedge clk) disable iff (rst)
        enc_done |-> !enc_wr && $past(enc_wr) && $past(enc_cmd.done));

endmodule

// File: design/xfer_req_if.sv
`timescale 1ns/1ps
// request fields are sampled only at a start strobe; the client holds them stable in that cycle
interface xfer_req_if;
    import ddr_geom_pkg::*;

    bank_t     bank;            // bank for the whole sequence
    row_t      row;             // row to open
    col8_t     start_col;       // first column in 8-bursts
    xfer_num_t num128;          // bursts, 0 means 64
    logic      skip_next_page;  // keep external buffer position

    // client side
    modport source (
        output bank, row, start_col, num128, skip_next_page
    );

    // encoder side
    modport sink (
        input bank, row, start_col, num128, skip_next_page
    );

endinterface

// File: design/ddr_cmd_pkg.sv
// sequencer word format for the linear encoder; the field order is fixed by the sequencer
package ddr_cmd_pkg;

    localparam int PAUSE_BITS = 6;  // idle cycles field width

    // sequencer opcodes, values match the sequencer decode
    typedef enum logic [2:0] {
        NOP       = 3'd0,
        ACTIVATE  = 3'd1,
        READ      = 3'd2,
        WRITE     = 3'd3,
        PRECHARGE = 3'd4
    } ddr_op_e;

    // transfer direction of one encoder instance
    typedef enum logic {
        DIR_RD = 1'b0,
        DIR_WR = 1'b1
    } xfer_dir_e;

    // one 32-bit sequencer word, top bit first
    typedef struct packed {
        ddr_op_e                 op;        // opcode
        ddr_geom_pkg::bank_t     bank;      // bank on every word
        ddr_geom_pkg::row_t      addr;      // row or column<<3
        logic                    done;      // last word of sequence
        logic                    late_sel;  // late/early command slot
        logic                    buf_rst;   // restart external data buffer
        logic                    buf_inc;   // step external data buffer
        logic                    dq_en;     // drive DQ, writes only
        logic [PAUSE_BITS-1:0]   pause;     // idle cycles after word
    } enc_cmd_t;

    // ACTIVATE to first column command
    localparam logic [PAUSE_BITS-1:0] T_RCD_PAUSE = 6'd4;

    // pause after the last column word, indexed by xfer_dir_e
    // write needs recovery before precharge, read only the burst
    localparam logic [1:0][PAUSE_BITS-1:0] T_WR_PAUSE = {6'd6, 6'd2};

endpackage

// File: design/ddr_geom_pkg.sv
// geometry of one DDR3 channel; fixed 8-bursts, one bank per sequence, no parameter override
package ddr_geom_pkg;

    localparam int ADDRESS_NUMBER = 15;                  // row address width
    localparam int COLADDR_NUMBER = 10;                  // column address width
    localparam int NUM_XFER_BITS  = 6;                   // burst count width, 0 means 64
    localparam int BUF_ADDR_BITS  = 7;                   // command buffer address width
    localparam int BANK_BITS      = 3;                   // DDR3 has 8 banks
    localparam int COL8_BITS      = COLADDR_NUMBER - 3;  // column in units of 8-bursts
    localparam int BUF_DEPTH      = 1 << BUF_ADDR_BITS;  // 128 words

    // bank select
    typedef logic [BANK_BITS-1:0] bank_t;

    // full row address, also wide enough for a column address word
    typedef logic [ADDRESS_NUMBER-1:0] row_t;

    // start column, low 3 bits implied zero
    typedef logic [COL8_BITS-1:0] col8_t;

    // bursts per sequence
    typedef logic [NUM_XFER_BITS-1:0] xfer_num_t;

endpackage
